// File: sram_test_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet layout, widths and sram depths for the test harness
// sram depths must be powers of two as addresses wrap modulo depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sram_test_pkg;

   // bank geometry
   localparam int N_SRAMS = 4;
   localparam int SEL_W   = 2;
   localparam int ADDR_W  = 10;
   localparam int DATA_W  = 32;
   localparam int MASK_W  = 4;
   localparam int BYTE_W  = DATA_W / MASK_W;

   // per-sram address width, smallest first
   localparam int SRAM_ADDR_W [N_SRAMS] = '{8, 9, 10, 10};

   // scan packet, 93 bits in total
   localparam int PACKET_W = 93;

   // lsb position of each field, msb field first
   localparam int SEL_LSB    = 91;
   localparam int ADDR0_LSB  = 81;
   localparam int DIN0_LSB   = 49;
   localparam int CSB0_LSB   = 48;
   localparam int WEB0_LSB   = 47;
   localparam int WMASK0_LSB = 43;
   localparam int ADDR1_LSB  = 33;
   localparam int DIN1_LSB   = 1;
   localparam int CSB1_LSB   = 0;

   // load sample to readback update
   localparam int ISSUE_LAT = 3;

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [MASK_W-1:0]   wmask_t;
   typedef logic [SEL_W-1:0]    sel_t;
   typedef logic [PACKET_W-1:0] packet_t;
   typedef logic [N_SRAMS-1:0]  csb_vec_t;

   // issue sequence of the controller
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT,
      ST_CAPTURE
   } ctrl_state_t;

endpackage

// File: sram_1rw1r.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral model, contents are not reset
// port 1 read of a word being written returns the old data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sram_1rw1r
   import sram_test_pkg::*;
#(
   parameter int ADDR_W = sram_test_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              csb0_i,
   input  logic              web0_i,
   input  wmask_t            wmask0_i,
   input  logic [ADDR_W-1:0] addr0_i,
   input  data_t             din0_i,
   output data_t             dout0_o,
   input  logic              csb1_i,
   input  logic [ADDR_W-1:0] addr1_i,
   output data_t             dout1_o
);

   data_t mem [2**ADDR_W];

   // port 0 read/write
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // only enabled bytes are written
            for (int b = 0; b < MASK_W; b++) begin
               if (wmask0_i[b]) begin
                  mem[addr0_i][b*BYTE_W +: BYTE_W] <= din0_i[b*BYTE_W +: BYTE_W];
               end
            end
         end else begin
            dout0_o <= mem[addr0_i];
         end
      end
   end

   // port 1 read only
   // nonblocking write above keeps the old word visible here
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[addr1_i];
      end
   end

endmodule

// File: scan_chain.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet shifts in msb first, serial out is the current msb
// update has priority over shift
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module scan_chain
   import sram_test_pkg::*;
(
   input  logic    clk,
   input  logic    rstn,
   input  logic    shift_en_i,
   input  logic    serial_i,
   input  logic    upd_i,
   input  logic    upd_rd0_i,
   input  logic    upd_rd1_i,
   input  data_t   rd0_i,
   input  data_t   rd1_i,
   output logic    serial_o,
   output packet_t packet_o
);

   packet_t packet_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         packet_q <= '0;
      end else if (upd_i) begin
         // readback lands in the din fields
         if (upd_rd0_i) begin
            packet_q[DIN0_LSB +: DATA_W] <= rd0_i;
         end
         if (upd_rd1_i) begin
            packet_q[DIN1_LSB +: DATA_W] <= rd1_i;
         end
      end else if (shift_en_i) begin
         // new bit enters at the lsb
         packet_q <= {packet_q[PACKET_W-2:0], serial_i};
      end
   end

   // straight from the register, no extra flop
   assign serial_o = packet_q[PACKET_W-1];

   // whole packet to the controller
   assign packet_o = packet_q;

endmodule

// File: sram_test_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed latency issue sequence with no handshake
// loads while busy are dropped, not queued
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sram_test_ctrl
   import sram_test_pkg::*;
(
   input  logic     clk,
   input  logic     rstn,
   input  logic     scan_i,
   input  logic     load_i,
   input  logic     global_csb_i,
   input  packet_t  packet_i,
   output logic     shift_en_o,
   output logic     upd_o,
   output logic     upd_rd0_o,
   output logic     upd_rd1_o,
   output data_t    rd0_o,
   output data_t    rd1_o,
   output addr_t    addr0_o,
   output addr_t    addr1_o,
   output data_t    din0_o,
   output logic     web0_o,
   output wmask_t   wmask0_o,
   output csb_vec_t csb0_o,
   output csb_vec_t csb1_o,
   input  data_t    dout0_i [N_SRAMS],
   input  data_t    dout1_i [N_SRAMS]
);

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   logic        issue;
   sel_t        sel_q;

   // packet fields
   sel_t   pkt_sel;
   addr_t  pkt_addr0;
   data_t  pkt_din0;
   logic   pkt_csb0;
   logic   pkt_web0;
   wmask_t pkt_wmask0;
   addr_t  pkt_addr1;
   logic   pkt_csb1;

   // one low bit for the selected sram, all high when off
   function automatic csb_vec_t csb_decode(input sel_t sel, input logic off);
      csb_vec_t v;
      v = '1;
      if (!off) begin
         v[sel] = 1'b0;
      end
      return v;
   endfunction

   assign pkt_sel    = packet_i[SEL_LSB +: SEL_W];
   assign pkt_addr0  = packet_i[ADDR0_LSB +: ADDR_W];
   assign pkt_din0   = packet_i[DIN0_LSB +: DATA_W];
   assign pkt_csb0   = packet_i[CSB0_LSB];
   assign pkt_web0   = packet_i[WEB0_LSB];
   assign pkt_wmask0 = packet_i[WMASK0_LSB +: MASK_W];
   assign pkt_addr1  = packet_i[ADDR1_LSB +: ADDR_W];
   assign pkt_csb1   = packet_i[CSB1_LSB];

   // scan and load only count while idle
   assign issue      = load_i && (state_q == ST_IDLE);
   assign shift_en_o = scan_i && (state_q == ST_IDLE);

   // readback strobe for the edge that ends capture
   assign upd_o = (state_q == ST_CAPTURE);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (load_i) begin
               state_d = ST_ISSUE;
            end
         end
         // srams sample on the edge leaving issue
         ST_ISSUE:   state_d = ST_WAIT;
         // read data valid, captured on the way out
         ST_WAIT:    state_d = ST_CAPTURE;
         ST_CAPTURE: state_d = ST_IDLE;
         default:    state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q   <= ST_IDLE;
         csb0_o    <= '1;
         csb1_o    <= '1;
         sel_q     <= '0;
         upd_rd0_o <= 1'b0;
         upd_rd1_o <= 1'b0;
      end else begin
         state_q <= state_d;
         // chip selects low for the issue cycle only
         csb0_o  <= '1;
         csb1_o  <= '1;
         if (issue) begin
            csb0_o    <= csb_decode(pkt_sel, global_csb_i | pkt_csb0);
            csb1_o    <= csb_decode(pkt_sel, global_csb_i | pkt_csb1);
            sel_q     <= pkt_sel;
            // port 0 readback only on a read
            upd_rd0_o <= !global_csb_i && !pkt_csb0 && pkt_web0;
            upd_rd1_o <= !global_csb_i && !pkt_csb1;
         end
      end
   end

   // shared port signals, meaningless while csb is high
   always_ff @(posedge clk) begin
      if (issue) begin
         addr0_o  <= pkt_addr0;
         din0_o   <= pkt_din0;
         web0_o   <= pkt_web0;
         wmask0_o <= pkt_wmask0;
         addr1_o  <= pkt_addr1;
      end
   end

   // hold the selected sram outputs
   always_ff @(posedge clk) begin
      if (state_q == ST_WAIT) begin
         rd0_o <= dout0_i[sel_q];
         rd1_o <= dout1_i[sel_q];
      end
   end

endmodule

// File: sram_test_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single clock for scan, controller and all srams
// scan and load are ignored for three cycles after a load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sram_test_top
   import sram_test_pkg::*;
(
   input  logic clk,
   input  logic rstn,
   input  logic gpio_scan_i,
   input  logic gpio_in_i,
   input  logic gpio_sram_load_i,
   input  logic global_csb_i,
   output logic gpio_out_o
);

   // scan chain <-> controller
   packet_t packet;
   logic    shift_en;
   logic    upd;
   logic    upd_rd0;
   logic    upd_rd1;
   data_t   rd0;
   data_t   rd1;

   // shared sram port signals
   addr_t    addr0;
   addr_t    addr1;
   data_t    din0;
   logic     web0;
   wmask_t   wmask0;
   // one chip select per sram, active low
   csb_vec_t csb0;
   csb_vec_t csb1;

   // sram outputs back to the controller
   data_t dout0 [N_SRAMS];
   data_t dout1 [N_SRAMS];

   scan_chain u_scan (
      .clk        (clk),
      .rstn       (rstn),
      .shift_en_i (shift_en),
      .serial_i   (gpio_in_i),
      .upd_i      (upd),
      .upd_rd0_i  (upd_rd0),
      .upd_rd1_i  (upd_rd1),
      .rd0_i      (rd0),
      .rd1_i      (rd1),
      .serial_o   (gpio_out_o),
      .packet_o   (packet)
   );

   sram_test_ctrl u_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .scan_i       (gpio_scan_i),
      .load_i       (gpio_sram_load_i),
      .global_csb_i (global_csb_i),
      .packet_i     (packet),
      .shift_en_o   (shift_en),
      .upd_o        (upd),
      .upd_rd0_o    (upd_rd0),
      .upd_rd1_o    (upd_rd1),
      .rd0_o        (rd0),
      .rd1_o        (rd1),
      .addr0_o      (addr0),
      .addr1_o      (addr1),
      .din0_o       (din0),
      .web0_o       (web0),
      .wmask0_o     (wmask0),
      .csb0_o       (csb0),
      .csb1_o       (csb1),
      .dout0_i      (dout0),
      .dout1_i      (dout1)
   );

   // smaller srams take only the low address bits
   for (genvar i = 0; i < N_SRAMS; i++) begin : g_sram
      sram_1rw1r #(
         .ADDR_W (SRAM_ADDR_W[i])
      ) u_sram (
         .clk      (clk),
         .csb0_i   (csb0[i]),
         .web0_i   (web0),
         .wmask0_i (wmask0),
         .addr0_i  (addr0[SRAM_ADDR_W[i]-1:0]),
         .din0_i   (din0),
         .dout0_o  (dout0[i]),
         .csb1_i   (csb1[i]),
         .addr1_i  (addr1[SRAM_ADDR_W[i]-1:0]),
         .dout1_o  (dout1[i])
      );
   end

endmodule

// File: tb_sram_test_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into every sram_test_ctrl instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_sram_test_props
   import sram_test_pkg::*;
(
   input logic        clk,
   input logic        rstn,
   input logic        global_csb_i,
   input csb_vec_t    csb0_i,
   input csb_vec_t    csb1_i,
   input ctrl_state_t state_i
);

   timeunit 1ns;
   timeprecision 1ps;

   // only the selected sram may be enabled
   a_csb_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(~csb0_i) && $onehot0(~csb1_i))
      else $error("more than one chip select low on a port");

   // chip selects are registered, so the override shows one cycle later
   a_global_off: assert property (@(posedge clk) disable iff (!rstn)
      global_csb_i |=> (csb0_i == '1) && (csb1_i == '1))
      else $error("chip select low while global_csb_i was high");

   a_csb_issue_only: assert property (@(posedge clk) disable iff (!rstn)
      (state_i != ST_ISSUE) |-> (csb0_i == '1) && (csb1_i == '1))
      else $error("chip select low outside the issue state");

   // fixed latency back to idle
   a_issue_lat: assert property (@(posedge clk) disable iff (!rstn)
      $fell(state_i == ST_IDLE) |-> (state_i != ST_IDLE)[*ISSUE_LAT] ##1 (state_i == ST_IDLE))
      else $error("controller did not return to idle after the fixed latency");

endmodule

bind sram_test_ctrl tb_sram_test_props u_props (
   .clk          (clk),
   .rstn         (rstn),
   .global_csb_i (global_csb_i),
   .csb0_i       (csb0_o),
   .csb1_i       (csb1_o),
   .state_i      (state_q)
);

// File: tb_sram_test_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vectors come from sram_testdata.hex, run from the project root
// stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_sram_test_top
   import sram_test_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // tokens per line of the data file
   localparam int FIELDS  = 12;
   localparam int MAX_VEC = 64;

   logic clk;
   logic rstn;
   logic gpio_scan_i;
   logic gpio_in_i;
   logic gpio_sram_load_i;
   logic global_csb_i;
   logic gpio_out_o;

   // unread entries stay x, which marks the end of the vectors
   logic [31:0] td [FIELDS*MAX_VEC];
   int          n_vec;
   int          err_cnt;
   int          seed;
   logic        vec_ready;

   sram_test_top dut0 (
      .clk              (clk),
      .rstn             (rstn),
      .gpio_scan_i      (gpio_scan_i),
      .gpio_in_i        (gpio_in_i),
      .gpio_sram_load_i (gpio_sram_load_i),
      .global_csb_i     (global_csb_i),
      .gpio_out_o       (gpio_out_o)
   );

   // 8 ns period
   always #4 clk = ~clk;

   // fields of one line in packet order, msb first
   function automatic packet_t build_packet(input int base);
      packet_t p;
      p = {td[base+1][SEL_W-1:0], td[base+2][ADDR_W-1:0], td[base+3],
           td[base+4][0], td[base+5][0], td[base+6][MASK_W-1:0],
           td[base+7][ADDR_W-1:0], td[base+8], td[base+9][0]};
      return p;
   endfunction

   task automatic stop_on_error(input string msg);
      err_cnt++;
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic shift_packet_in(input packet_t p);
      for (int i = PACKET_W-1; i >= 0; i--) begin
         @(negedge clk);
         gpio_scan_i = 1'b1;
         gpio_in_i   = p[i];
      end
   endtask

   // load edge plus the fixed latency, busy cycles may carry noise
   task automatic issue_and_wait(input logic no_load, input logic csb_off,
                                 input logic busy_noise);
      @(negedge clk);
      gpio_scan_i      = 1'b0;
      gpio_in_i        = 1'b0;
      gpio_sram_load_i = !no_load;
      global_csb_i     = csb_off;
      for (int k = 0; k < ISSUE_LAT; k++) begin
         @(negedge clk);
         gpio_sram_load_i = busy_noise;
         gpio_scan_i      = busy_noise;
         gpio_in_i        = 1'($random(seed));
      end
      // readback is in the scan register from here
      @(negedge clk);
      gpio_sram_load_i = 1'b0;
      gpio_scan_i      = 1'b0;
      global_csb_i     = 1'b0;
   endtask

   // only the din fields may change on readback
   task automatic shift_out_and_check(input packet_t sent, input data_t exp0,
                                      input data_t exp1, input int vec);
      packet_t got;
      logic    in_din;
      for (int i = PACKET_W-1; i >= 0; i--) begin
         got[i] = gpio_out_o;
         in_din = (i >= DIN0_LSB && i < DIN0_LSB + DATA_W) ||
                  (i >= DIN1_LSB && i < DIN1_LSB + DATA_W);
         // every other field comes back as it was sent
         if (!in_din) begin
            assert (gpio_out_o === sent[i])
               else stop_on_error($sformatf("FAIL gpio_out_o vector %0d bit %0d: got %h expected %h",
                                            vec, i, gpio_out_o, sent[i]));
         end
         // filler shifted in behind the readback
         gpio_scan_i = 1'b1;
         gpio_in_i   = 1'($random(seed));
         @(negedge clk);
      end
      gpio_scan_i = 1'b0;
      assert (got[DIN0_LSB +: DATA_W] === exp0)
         else stop_on_error($sformatf("FAIL din0 vector %0d: got %h expected %h",
                                      vec, got[DIN0_LSB +: DATA_W], exp0));
      assert (got[DIN1_LSB +: DATA_W] === exp1)
         else stop_on_error($sformatf("FAIL din1 vector %0d: got %h expected %h",
                                      vec, got[DIN1_LSB +: DATA_W], exp1));
   endtask

   initial begin
      packet_t pkt;
      int      base;
      clk              = 1'b0;
      rstn             = 1'b0;
      gpio_scan_i      = 1'b0;
      gpio_in_i        = 1'b0;
      gpio_sram_load_i = 1'b0;
      global_csb_i     = 1'b0;
      seed             = 69;
      err_cnt          = 0;
      n_vec            = 0;
      vec_ready        = 1'b0;
      $readmemh("sram_testdata.hex", td);
      while (n_vec < MAX_VEC && !$isunknown(td[n_vec*FIELDS])) begin
         n_vec++;
      end
      vec_ready = 1'b1;
      assert (n_vec > 0)
         else stop_on_error("no test vectors could be read from sram_testdata.hex");
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      assert (gpio_out_o === 1'b0)
         else stop_on_error($sformatf("FAIL gpio_out_o after reset: got %h expected %h",
                                      gpio_out_o, 1'b0));
      for (int v = 0; v < n_vec; v++) begin
         base = v * FIELDS;
         pkt  = build_packet(base);
         shift_packet_in(pkt);
         issue_and_wait(td[base][0], td[base][1], td[base][2]);
         shift_out_and_check(pkt, td[base+10], td[base+11], v);
      end
      if (err_cnt == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Checks failed");
         $fatal(1, "errors were found");
      end
   end

   // about 192 cycles per vector, 200 allowed
   initial begin
      longint limit_ns;
      wait (vec_ready);
      limit_ns = (longint'(n_vec) * 200 + 50) * 8;
      #(limit_ns);
      $display("watchdog: the test did not finish in time");
      $display("Checks failed");
      $fatal(1, "watchdog timeout");
   end

endmodule

// File: sram_testdata.hex
// ctrl sel addr0 din0 csb0 web0 wmask0 addr1 din1 csb1 exp_din0 exp_din1
// ctrl bit 0 skips the load, bit 1 sets global_csb_i, bit 2 adds busy noise
1 2 155 A5A5F00F 0 1 F 2AA 0F0F1234 0 A5A5F00F 0F0F1234
0 0 010 11223344 0 0 F 000 00000000 1 11223344 00000000
0 0 010 AABBCCDD 0 0 5 000 00000000 1 AABBCCDD 00000000
0 0 010 DEADBEEF 0 1 0 000 CAFEF00D 1 11BB33DD CAFEF00D
0 1 020 01020304 0 0 F 000 00000000 1 01020304 00000000
0 1 020 F0E0D0C0 0 0 F 020 12345678 0 F0E0D0C0 01020304
0 1 020 00000000 0 1 0 020 00000000 0 F0E0D0C0 F0E0D0C0
0 0 135 5A5A0001 0 0 F 000 00000000 1 5A5A0001 00000000
0 0 035 00000000 0 1 0 335 00000000 0 5A5A0001 5A5A0001
0 3 035 77777777 0 0 F 000 00000000 1 77777777 00000000
0 0 035 00000000 0 1 0 010 00000000 0 5A5A0001 11BB33DD
0 3 035 00000000 0 1 0 035 00000000 0 77777777 77777777
0 1 3FF 0BADCAFE 0 0 F 000 00000000 1 0BADCAFE 00000000
0 1 1FF 00000000 0 1 0 1FF 00000000 0 0BADCAFE 0BADCAFE
2 0 010 99999999 0 0 F 010 ABCD0123 0 99999999 ABCD0123
0 0 010 00000000 0 1 0 135 00000000 0 11BB33DD 5A5A0001
2 0 010 13579BDF 0 1 0 010 2468ACE0 0 13579BDF 2468ACE0
0 3 000 87654321 1 1 0 035 00000000 0 87654321 77777777
4 2 055 C0FFEE00 0 0 F 000 00000000 1 C0FFEE00 00000000
4 2 055 00000000 0 1 0 055 FFFFFFFF 0 C0FFEE00 C0FFEE00
4 2 055 00000011 0 0 1 055 00000000 0 00000011 C0FFEE00
0 2 055 00000000 0 1 0 055 00000000 0 C0FFEE11 C0FFEE11

// File: sram_test_top.f
sram_test_pkg.sv
sram_1rw1r.sv
scan_chain.sv
sram_test_ctrl.sv
sram_test_top.sv
tb_sram_test_props.sv
tb_sram_test_top.sv

// File: Bender.yml
package:
  name: sram_test

sources:
  - files:
      - sram_test_pkg.sv
      - sram_1rw1r.sv
      - scan_chain.sv
      - sram_test_ctrl.sv
      - sram_test_top.sv
  - target: test
    files:
      - tb_sram_test_props.sv
      - tb_sram_test_top.sv
